/* tb.f */
+incdir+hdl
hdl/afu_csr_pkg.sv
hdl/afu_csr_rd.sv
hdl/afu_csr_wr.sv
hdl/sreg_file.sv
hdl/afu_csr_top.sv
bench/afu_csr_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the CSR block testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module afu_csr_tb -f tb.f -o afu_csr_sim

./obj_dir/afu_csr_sim | tee sim.log

if grep -q "test passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

/* bench/afu_csr_tb.sv */
/*
 * Testbench for the CSR block.
 * Inputs change on the rising edge and responses are sampled on the
 * falling edge, where the combinational read answer has settled.
 * A model of the sixteen SREGs gives the expected indirect read data.
 * Only one SREG read is ever outstanding, as the block requires.
 */

`timescale 1ns/1ps
`default_nettype none

`include "afu_csr_consts.svh"

module afu_csr_tb
    import afu_csr_pkg::*;
;

    localparam afu_id_t TB_AFU_ID = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    localparam int MAX_STEPS = 24;
    localparam int RSP_TIMEOUT = 50;

    // How a table entry is expected to be answered
    localparam logic [1:0] RSP_NONE = 2'd0;
    localparam logic [1:0] RSP_NOW = 2'd1;
    localparam logic [1:0] RSP_LATER = 2'd2;

    logic       clk;
    logic       reset;
    logic       mmio_rd_valid;
    logic       mmio_wr_valid;
    mmio_addr_t mmio_addr;
    tid_t       mmio_tid;
    csr_data_t  mmio_wr_data;
    logic       rd_rsp_valid;
    tid_t       rd_rsp_tid;
    csr_data_t  rd_rsp_data;

    // Stimulus table, one column per array
    string      step_name [MAX_STEPS];
    bit         step_rd [MAX_STEPS];
    mmio_addr_t step_addr [MAX_STEPS];
    tid_t       step_tid [MAX_STEPS];
    csr_data_t  step_data [MAX_STEPS];
    logic [1:0] step_rsp [MAX_STEPS];
    csr_data_t  step_exp [MAX_STEPS];
    int         num_steps;

    // Mirror of the SREG bank and its address register
    csr_data_t  model_regs [16];
    sreg_addr_t model_addr;

    int     error_count;
    int     pass_count;
    int     fail_count;
    integer seed;

    afu_csr_top #(
        .AFU_ID (TB_AFU_ID)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .mmio_rd_valid (mmio_rd_valid),
        .mmio_wr_valid (mmio_wr_valid),
        .mmio_addr     (mmio_addr),
        .mmio_tid      (mmio_tid),
        .mmio_wr_data  (mmio_wr_data),
        .rd_rsp_valid  (rd_rsp_valid),
        .rd_rsp_tid    (rd_rsp_tid),
        .rd_rsp_data   (rd_rsp_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // DFH holds the feature type in bits 63 to 60 and the next offset in 39 to 16
    function automatic csr_data_t dfh_value();
        csr_data_t v;
        v = '0;
        v[63:60] = `DFH_TYPE_AFU;
        v[39:16] = `DFH_NEXT_OFFSET;
        return v;
    endfunction

    function automatic csr_data_t direct_value(input int idx);
        case (idx)
            0: return dfh_value();
            1: return TB_AFU_ID[63:0];
            2: return TB_AFU_ID[127:64];
            default: return '0;
        endcase
    endfunction

    // Byte-pair address of an 8-byte CSR, in 4-byte units
    function automatic mmio_addr_t addr_of_index(input csr_index_t idx);
        return {12'h0, idx, 1'b0};
    endfunction

    task automatic add_step(input string name, input bit rd, input mmio_addr_t addr,
                            input tid_t tid, input csr_data_t data, input logic [1:0] rsp,
                            input csr_data_t expected);
        step_name[num_steps] = name;
        step_rd[num_steps] = rd;
        step_addr[num_steps] = addr;
        step_tid[num_steps] = tid;
        step_data[num_steps] = data;
        step_rsp[num_steps] = rsp;
        step_exp[num_steps] = expected;
        num_steps++;
    endtask

    // Out-of-range writes are ignored, as are writes to any other index
    task automatic model_write(input mmio_addr_t addr, input csr_data_t data);
        if (addr <= `CSR_ADDR_MAX)
        begin
            if (addr[3:1] == `CSR_IDX_SREG_ADDR)
                model_addr = data[3:0];
            else if (addr[3:1] == `CSR_IDX_SREG_DATA)
                model_regs[model_addr] = data;
        end
    endtask

    task automatic check_value(input string name, input csr_data_t expected,
                               input csr_data_t actual);
        if (expected !== actual)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_problem(input string text);
        $display("%s", text);
        error_count++;
    endtask

    // One request cycle, then sample the answer in that same cycle
    task automatic issue(input bit rd, input mmio_addr_t addr, input tid_t tid,
                         input csr_data_t data);
        @(posedge clk);
        mmio_rd_valid <= rd;
        mmio_wr_valid <= !rd;
        mmio_addr <= addr;
        mmio_tid <= tid;
        mmio_wr_data <= data;
        @(negedge clk);
    endtask

    task automatic go_idle();
        @(posedge clk);
        mmio_rd_valid <= 1'b0;
        mmio_wr_valid <= 1'b0;
        @(negedge clk);
    endtask

    // Idle cycles until a response shows up or the limit runs out
    task automatic wait_response(input int limit, output bit found, output int cycles);
        found = 1'b0;
        cycles = 0;
        while (!found && (cycles < limit))
        begin
            go_idle();
            cycles++;
            if (rd_rsp_valid)
                found = 1'b1;
        end
    endtask

    task automatic expect_quiet(input string name, input int n);
        repeat (n)
        begin
            go_idle();
            if (rd_rsp_valid)
                report_problem($sformatf("%s: unexpected response with tag %h", name, rd_rsp_tid));
        end
    endtask

    task automatic expect_direct(input string name, input tid_t tid, input csr_data_t expected);
        if (!rd_rsp_valid)
        begin
            report_problem($sformatf("%s: no response in the request cycle", name));
        end
        else
        begin
            check_value({name, " data"}, expected, rd_rsp_data);
            check_value({name, " tag"}, csr_data_t'(tid), csr_data_t'(rd_rsp_tid));
        end
    endtask

    // An SREG read gets nothing back in the cycle it is issued
    task automatic expect_no_answer(input string name);
        if (rd_rsp_valid)
            report_problem($sformatf("%s: SREG read answered in its request cycle", name));
    endtask

    // Waits for the held SREG answer and checks its arrival cycle
    task automatic expect_sreg(input string name, input tid_t tid, input int latency);
        csr_data_t expected;
        bit        found;
        int        cycles;
        expected = model_regs[model_addr];
        wait_response(RSP_TIMEOUT, found, cycles);
        if (!found)
        begin
            report_problem($sformatf("%s: no SREG response within %0d cycles", name, RSP_TIMEOUT));
        end
        else
        begin
            check_value({name, " latency"}, csr_data_t'(latency), csr_data_t'(cycles));
            check_value({name, " data"}, expected, rd_rsp_data);
            check_value({name, " tag"}, csr_data_t'(tid), csr_data_t'(rd_rsp_tid));
        end
        // A second answer would mean the read was duplicated
        expect_quiet(name, 5);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before)
        begin
            pass_count++;
            $display("PASS %s", name);
        end
        else
        begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    // SREG answer falls due in the middle of a run of direct reads
    task automatic collision_check();
        int   errs_before;
        int   k;
        tid_t sreg_tag;
        errs_before = error_count;
        sreg_tag = 9'h0c3;
        issue(1'b0, addr_of_index(`CSR_IDX_SREG_ADDR), '0, 64'd12);
        model_write(addr_of_index(`CSR_IDX_SREG_ADDR), 64'd12);
        issue(1'b0, addr_of_index(`CSR_IDX_SREG_DATA), '0, 64'h0c0f_fee0_5a5a_a5a5);
        model_write(addr_of_index(`CSR_IDX_SREG_DATA), 64'h0c0f_fee0_5a5a_a5a5);
        issue(1'b1, addr_of_index(`CSR_IDX_SREG_ADDR), sreg_tag, '0);
        expect_no_answer("collision");
        for (k = 0; k < `SREG_LATENCY + 2; k++)
        begin
            issue(1'b1, addr_of_index(csr_index_t'(k % 5)), tid_t'(k + 1), '0);
            expect_direct($sformatf("collision_direct_%0d", k), tid_t'(k + 1), direct_value(k % 5));
        end
        // First free cycle follows right after the direct reads
        expect_sreg("collision_sreg", sreg_tag, 1);
        finish_test("collision", errs_before);
    endtask

    initial
    begin
        int        i;
        int        errs_before;
        sreg_addr_t r_addr;
        csr_data_t r_data;
        tid_t      r_tag;

        reset = 1'b1;
        mmio_rd_valid = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_wr_data = '0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        num_steps = 0;
        seed = 29;
        model_addr = '0;
        for (i = 0; i < 16; i++)
            model_regs[i] = '0;

        add_step("dfh_read", 1'b1, 16'd0, 9'h011, '0, RSP_NOW, direct_value(0));
        add_step("dfh_odd_read", 1'b1, 16'd1, 9'h012, '0, RSP_NOW, direct_value(0));
        add_step("id_low_read", 1'b1, 16'd2, 9'h013, '0, RSP_NOW, direct_value(1));
        add_step("id_high_read", 1'b1, 16'd4, 9'h1ff, '0, RSP_NOW, direct_value(2));
        add_step("rsvd0_read", 1'b1, 16'd6, 9'h020, '0, RSP_NOW, '0);
        add_step("rsvd1_read", 1'b1, 16'd8, 9'h021, '0, RSP_NOW, '0);
        add_step("sreg_data_read", 1'b1, 16'd12, 9'h022, '0, RSP_NOW, '0);
        add_step("index7_read", 1'b1, 16'd15, 9'h023, '0, RSP_NONE, '0);
        add_step("addr14_read", 1'b1, 16'd14, 9'h024, '0, RSP_NONE, '0);
        add_step("far_read", 1'b1, 16'h0100, 9'h025, '0, RSP_NONE, '0);
        add_step("sreg_addr_write", 1'b0, 16'd10, '0, 64'd3, RSP_NONE, '0);
        add_step("sreg_data_write", 1'b0, 16'd12, '0, 64'hdead_beef_0123_4567, RSP_NONE, '0);
        add_step("sreg_read", 1'b1, 16'd10, 9'h0a5, '0, RSP_LATER, '0);
        add_step("sreg_addr_odd_write", 1'b0, 16'd11, '0, 64'hf9, RSP_NONE, '0);
        add_step("sreg_data_write2", 1'b0, 16'd12, '0, 64'h1357_9bdf_2468_ace0, RSP_NONE, '0);
        add_step("sreg_odd_read", 1'b1, 16'd11, 9'h15a, '0, RSP_LATER, '0);
        add_step("sreg_addr_back", 1'b0, 16'd10, '0, 64'd3, RSP_NONE, '0);
        add_step("far_data_write", 1'b0, 16'h010c, '0, 64'hffff_ffff_ffff_ffff, RSP_NONE, '0);
        add_step("sreg_reread", 1'b1, 16'd10, 9'h100, '0, RSP_LATER, '0);

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        errs_before = error_count;
        expect_quiet("idle_after_reset", 10);
        finish_test("idle_after_reset", errs_before);

        for (i = 0; i < num_steps; i++)
        begin
            errs_before = error_count;
            issue(step_rd[i], step_addr[i], step_tid[i], step_data[i]);
            if (!step_rd[i])
                model_write(step_addr[i], step_data[i]);
            case (step_rsp[i])
                RSP_NOW:
                    expect_direct(step_name[i], step_tid[i], step_exp[i]);
                RSP_LATER:
                begin
                    expect_no_answer(step_name[i]);
                    expect_sreg(step_name[i], step_tid[i], `SREG_LATENCY + 1);
                end
                default:
                begin
                    if (rd_rsp_valid)
                        report_problem($sformatf("%s: response where none is expected",
                                                 step_name[i]));
                    if (step_rd[i])
                        expect_quiet(step_name[i], 10);
                end
            endcase
            finish_test(step_name[i], errs_before);
        end

        collision_check();

        for (i = 0; i < 20; i++)
        begin
            errs_before = error_count;
            r_addr = sreg_addr_t'($random(seed));
            r_data = {32'($random(seed)), 32'($random(seed))};
            r_tag = tid_t'($random(seed));
            issue(1'b0, addr_of_index(`CSR_IDX_SREG_ADDR), '0, csr_data_t'(r_addr));
            model_write(addr_of_index(`CSR_IDX_SREG_ADDR), csr_data_t'(r_addr));
            issue(1'b0, addr_of_index(`CSR_IDX_SREG_DATA), '0, r_data);
            model_write(addr_of_index(`CSR_IDX_SREG_DATA), r_data);
            issue(1'b1, addr_of_index(`CSR_IDX_SREG_ADDR), r_tag, '0);
            expect_no_answer($sformatf("random_pair_%0d", i));
            expect_sreg($sformatf("random_pair_%0d", i), r_tag, `SREG_LATENCY + 1);
            finish_test($sformatf("random_pair_%0d", i), errs_before);
        end

        $display("Pass count %0d, fail count %0d", pass_count, fail_count);
        if ((fail_count == 0) && (error_count == 0))
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/afu_csr_top.sv */
/*
 * CSR block of the accelerator unit, seen from the host MMIO port.
 * Read and write strobes are single cycle and never high together.
 * Responses cannot be back-pressured; direct reads answer in the same
 * cycle and SREG reads after SREG_LATENCY + 1 cycles or later.
 */

`timescale 1ns/1ps
`default_nettype none

module afu_csr_top
    import afu_csr_pkg::*;
#(
    parameter afu_id_t AFU_ID = '0
)
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  mmio_rd_valid,
    input  wire logic  mmio_wr_valid,
    input  mmio_addr_t mmio_addr,
    input  tid_t       mmio_tid,
    input  csr_data_t  mmio_wr_data,
    output logic       rd_rsp_valid,
    output tid_t       rd_rsp_tid,
    output csr_data_t  rd_rsp_data
);

    // Read side to register bank
    logic       sreg_rd_req;
    logic       sreg_rsp_valid;
    csr_data_t  sreg_rsp_data;

    // Write side to register bank
    sreg_addr_t sreg_addr;
    logic       sreg_wr_en;
    csr_data_t  sreg_wr_data;

    afu_csr_rd #(
        .AFU_ID (AFU_ID)
    ) u_rd (
        .clk            (clk),
        .reset          (reset),
        .mmio_rd_valid  (mmio_rd_valid),
        .mmio_addr      (mmio_addr),
        .mmio_tid       (mmio_tid),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data),
        .sreg_rd_req    (sreg_rd_req),
        .rd_rsp_valid   (rd_rsp_valid),
        .rd_rsp_tid     (rd_rsp_tid),
        .rd_rsp_data    (rd_rsp_data)
    );

    afu_csr_wr u_wr (
        .clk           (clk),
        .reset         (reset),
        .mmio_wr_valid (mmio_wr_valid),
        .mmio_addr     (mmio_addr),
        .mmio_wr_data  (mmio_wr_data),
        .sreg_addr     (sreg_addr),
        .sreg_wr_en    (sreg_wr_en),
        .sreg_wr_data  (sreg_wr_data)
    );

    sreg_file u_sreg (
        .clk            (clk),
        .reset          (reset),
        .sreg_addr      (sreg_addr),
        .sreg_wr_en     (sreg_wr_en),
        .sreg_wr_data   (sreg_wr_data),
        .sreg_rd_req    (sreg_rd_req),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

endmodule

`default_nettype wire

/* hdl/sreg_file.sv */
/*
 * Bank of sixteen 64-bit system registers.
 * A read request captures the address and the word is presented exactly
 * SREG_LATENCY cycles later for one cycle. Only one read may be in flight.
 * The word is sampled at the end of the countdown, so a write that lands
 * during the countdown is visible in the answer.
 */

`timescale 1ns/1ps
`default_nettype none

`include "afu_csr_consts.svh"

module sreg_file
    import afu_csr_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  sreg_addr_t sreg_addr,
    input  wire logic  sreg_wr_en,
    input  csr_data_t  sreg_wr_data,
    input  wire logic  sreg_rd_req,
    output logic       sreg_rsp_valid,
    output csr_data_t  sreg_rsp_data
);

    localparam int CNT_W = $clog2(`SREG_LATENCY + 1);

    csr_data_t   regs [16];
    sreg_state_t state;
    logic [CNT_W-1:0] cnt;
    sreg_addr_t  rd_addr;

    // Register writes, cleared on reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 16; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (sreg_wr_en)
        begin
            regs[sreg_addr] <= sreg_wr_data;
        end
    end

    // Countdown FSM
    // The request cycle counts as the first of the latency cycles
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= SREG_IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                SREG_IDLE:
                begin
                    if (sreg_rd_req)
                    begin
                        state <= SREG_BUSY;
                        cnt   <= CNT_W'(`SREG_LATENCY - 1);
                    end
                end
                SREG_BUSY:
                begin
                    if (cnt == CNT_W'(1))
                    begin
                        state <= SREG_HOLD;
                    end
                    cnt <= cnt - 1'b1;
                end
                default:
                begin
                    state <= SREG_IDLE;
                end
            endcase
        end
    end

    // Address capture and answer sampling
    always_ff @(posedge clk)
    begin
        if (sreg_rd_req && (state == SREG_IDLE))
        begin
            rd_addr <= sreg_addr;
        end
        if ((state == SREG_BUSY) && (cnt == CNT_W'(1)))
        begin
            sreg_rsp_data <= regs[rd_addr];
        end
    end

    assign sreg_rsp_valid = (state == SREG_HOLD);

    // Host keeps at most one SREG read outstanding
    a_one_read: assert property (
        @(posedge clk) disable iff (reset)
        sreg_rd_req |-> (state == SREG_IDLE)
    ) else $error("SREG read requested while another read is in flight");

endmodule

`default_nettype wire

/* hdl/afu_csr_wr.sv */
/*
 * MMIO write side of the CSR block.
 * A write to the SREG address CSR takes effect in the next cycle.
 * A write to the SREG data CSR becomes a registered one-cycle strobe, so
 * the host must not write the data CSR in two consecutive cycles.
 * Writes never produce a response.
 */

`timescale 1ns/1ps
`default_nettype none

`include "afu_csr_consts.svh"

module afu_csr_wr
    import afu_csr_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  mmio_wr_valid,
    input  mmio_addr_t mmio_addr,
    input  csr_data_t  mmio_wr_data,
    output sreg_addr_t sreg_addr,
    output logic       sreg_wr_en,
    output csr_data_t  sreg_wr_data
);

    logic       wr_ok;
    csr_index_t csr_idx;

    // Same range check and index decode as the read side
    assign wr_ok   = mmio_wr_valid && (mmio_addr <= `CSR_ADDR_MAX);
    assign csr_idx = mmio_addr[3:1];

    // SREG address latch and write strobe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sreg_addr  <= '0;
            sreg_wr_en <= 1'b0;
        end
        else
        begin
            sreg_wr_en <= wr_ok && (csr_idx == `CSR_IDX_SREG_DATA);
            if (wr_ok && (csr_idx == `CSR_IDX_SREG_ADDR))
            begin
                // Only the low bits address the sixteen registers
                sreg_addr <= sreg_addr_t'(mmio_wr_data[3:0]);
            end
        end
    end

    // Write data travels alongside the strobe
    always_ff @(posedge clk)
    begin
        if (wr_ok && (csr_idx == `CSR_IDX_SREG_DATA))
        begin
            sreg_wr_data <= mmio_wr_data;
        end
    end

    // Back-to-back data writes from the host would stretch the strobe
    a_strobe_pulse: assert property (
        @(posedge clk) disable iff (reset)
        sreg_wr_en |=> !sreg_wr_en
    ) else $error("SREG write strobe lasted more than one cycle");

endmodule

`default_nettype wire

/* hdl/afu_csr_rd.sv */
/*
 * MMIO read side of the CSR block.
 * Direct CSRs are answered combinationally in the request cycle.
 * An SREG read is forwarded to the register bank and its answer is held
 * until a cycle with no direct read, so direct reads always win.
 * Only one SREG answer can be held; the host must not issue a second
 * SREG read before the first is returned.
 */

`timescale 1ns/1ps
`default_nettype none

`include "afu_csr_consts.svh"

module afu_csr_rd
    import afu_csr_pkg::*;
#(
    parameter afu_id_t AFU_ID = '0
)
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic mmio_rd_valid,
    input  mmio_addr_t mmio_addr,
    input  tid_t       mmio_tid,
    input  wire logic  sreg_rsp_valid,
    input  csr_data_t  sreg_rsp_data,
    output logic       sreg_rd_req,
    output logic       rd_rsp_valid,
    output tid_t       rd_rsp_tid,
    output csr_data_t  rd_rsp_data
);

    // Address decode
    logic       addr_ok;
    csr_index_t csr_idx;

    // Direct read answer for this cycle
    logic      direct_rsp;
    csr_data_t direct_data;
    csr_data_t dfh;

    // Held SREG answer and the tag of the read that asked for it
    logic      hold_valid;
    csr_data_t hold_data;
    tid_t      sreg_tid;
    logic      did_sreg_rsp;

    // Upper address bits are covered by the range check, so the index
    // only needs bits 3 to 1
    assign addr_ok = (mmio_addr <= `CSR_ADDR_MAX);
    assign csr_idx = mmio_addr[3:1];

    // Feature type on top, next-feature offset in bits 39 to 16,
    // everything else zero
    assign dfh = {`DFH_TYPE_AFU, 20'h0, `DFH_NEXT_OFFSET, 16'h0};

    always_comb
    begin
        direct_rsp  = 1'b0;
        direct_data = '0;
        sreg_rd_req = 1'b0;

        if (mmio_rd_valid && addr_ok)
        begin
            case (csr_idx)
                `CSR_IDX_DFH:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = dfh;
                end
                `CSR_IDX_ID_L:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = AFU_ID[63:0];
                end
                `CSR_IDX_ID_H:
                begin
                    direct_rsp  = 1'b1;
                    direct_data = AFU_ID[127:64];
                end
                `CSR_IDX_RSVD0, `CSR_IDX_RSVD1, `CSR_IDX_SREG_DATA:
                begin
                    // Reserved words and the write-only data window read zero
                    direct_rsp  = 1'b1;
                    direct_data = '0;
                end
                `CSR_IDX_SREG_ADDR:
                begin
                    // Answer comes back later through the hold register
                    sreg_rd_req = 1'b1;
                end
                default:
                begin
                    // Index 7 is unmapped and gets no response
                    direct_rsp = 1'b0;
                end
            endcase
        end
    end

    // A held SREG answer goes out in any cycle not used by a direct read
    assign did_sreg_rsp = hold_valid && !direct_rsp;

    always_comb
    begin
        rd_rsp_valid = direct_rsp || hold_valid;
        if (direct_rsp)
        begin
            rd_rsp_tid  = mmio_tid;
            rd_rsp_data = direct_data;
        end
        else
        begin
            rd_rsp_tid  = sreg_tid;
            rd_rsp_data = hold_data;
        end
    end

    // Tag of the SREG read, kept until its answer is sent
    always_ff @(posedge clk)
    begin
        if (sreg_rd_req)
        begin
            sreg_tid <= mmio_tid;
        end
    end

    // Hold flag clears once the answer has been sent
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hold_valid <= 1'b0;
        end
        else if (did_sreg_rsp)
        begin
            hold_valid <= 1'b0;
        end
        else if (sreg_rsp_valid)
        begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sreg_rsp_valid)
        begin
            hold_data <= sreg_rsp_data;
        end
    end

    // The bank must not answer again while an earlier answer still waits
    // for a free response slot
    a_no_overrun: assert property (
        @(posedge clk) disable iff (reset)
        sreg_rsp_valid |-> !hold_valid
    ) else $error("SREG answer arrived while another was still held");

endmodule

`default_nettype wire

/* hdl/afu_csr_pkg.sv */
/*
 * Types shared by the CSR block.
 * All types are plain vectors sized to the MMIO port of the host.
 * Only one SREG read may be in flight, which the state enum reflects.
 */

`default_nettype none

package afu_csr_pkg;

    // MMIO address in 4-byte units
    typedef logic [15:0] mmio_addr_t;

    // Host transaction tag, returned with every read response
    typedef logic [8:0] tid_t;

    // One CSR or SREG data word
    typedef logic [63:0] csr_data_t;

    // 8-byte CSR index, address with its low bit dropped
    typedef logic [2:0] csr_index_t;

    // Index into the sixteen system registers
    typedef logic [3:0] sreg_addr_t;

    // Unit identifier, returned in two halves
    typedef logic [127:0] afu_id_t;

    // SREG read pipeline
    // Idle waits for a request, busy counts down the latency and
    // hold presents the word for one cycle
    typedef enum logic [1:0] {
        SREG_IDLE,
        SREG_BUSY,
        SREG_HOLD
    } sreg_state_t;

endpackage

`default_nettype wire

/* hdl/afu_csr_consts.svh */
/*
 * Constants shared by the CSR block and its testbench.
 * CSR indices are 8-byte word indices, i.e. the MMIO address (in 4-byte
 * units) with its low bit dropped.
 * The SREG read path counts down from SREG_LATENCY, which must be 2 or more.
 */

`ifndef AFU_CSR_CONSTS_SVH
`define AFU_CSR_CONSTS_SVH

// Direct CSR indices
`define CSR_IDX_DFH         3'd0
`define CSR_IDX_ID_L        3'd1
`define CSR_IDX_ID_H        3'd2
`define CSR_IDX_RSVD0       3'd3
`define CSR_IDX_RSVD1       3'd4

// Indirect SREG access window
`define CSR_IDX_SREG_ADDR   3'd5
`define CSR_IDX_SREG_DATA   3'd6

// Highest MMIO address that belongs to this block, in 4-byte units
`define CSR_ADDR_MAX        16'd13

// Device feature header fields
`define DFH_TYPE_AFU        4'h1
`define DFH_NEXT_OFFSET     24'h001000

// Cycles from an SREG read request to the register bank answer
`define SREG_LATENCY        3

`endif
